// File: Bender.yml
package:
  name: alu_two_stage

sources:
  - aluPkg.sv
  - carrySelectAdder.sv
  - aluOperandStage.sv
  - aluResultStage.sv
  - aluTop.sv
  - target: test
    files:
      - aluChecker.sv
      - aluTb.sv

// File: all.f
aluPkg.sv
carrySelectAdder.sv
aluOperandStage.sv
aluResultStage.sv
aluTop.sv
aluChecker.sv
aluTb.sv

// File: aluChecker.sv
/*
 * Bound assertions for the two-stage ALU.
 * Keeps a model of the result rules for the item sampled two unheld
 * edges back and checks valOut, srTOut, reset clearing and hold
 * stability. The testbench binds it into aluTop.
 */
`default_nettype none

module aluChecker #(
	parameter int DataWidth = aluPkg::DataWidth
) (
	input wire                   clock,
	input wire                   rstN,
	input wire                   exHold,
	input wire aluPkg::aluCtrl_t ctrl,
	input wire [DataWidth-1:0]   valRs,
	input wire [DataWidth-1:0]   valRt,
	input wire                   srT,
	input wire [DataWidth-1:0]   valOut,
	input wire                   srTOut
);
	timeunit 1ns;
	timeprecision 100ps;

	import aluPkg::*;

	typedef struct packed {
		aluCtrl_t             ctrl;
		logic [DataWidth-1:0] rs;
		logic [DataWidth-1:0] rt;
		logic                 t;
	} issue_t;

	issue_t               held;
	logic [DataWidth-1:0] expVal;
	logic                 expT;

	// returns {T, value} for one issued item
	function automatic logic [DataWidth:0] expectResult(issue_t it);
		logic [DataWidth-1:0]      mask;
		logic [DataWidth:0]        a;
		logic [DataWidth:0]        b;
		logic [DataWidth:0]        wide;
		logic signed [DataWidth:0] sa;
		logic signed [DataWidth:0] sb;
		logic [DataWidth-1:0]      val;
		logic                      t;
		int                        w;
		w = it.ctrl.qword ? DataWidth : HalfWidth;
		mask = {DataWidth{1'b1}} >> (DataWidth - w);
		a = {1'b0, it.rs & mask};
		b = {1'b0, it.rt & mask};
		// signed views of the W-bit operands
		sa = a << (DataWidth + 1 - w);
		sa = sa >>> (DataWidth + 1 - w);
		sb = b << (DataWidth + 1 - w);
		sb = sb >>> (DataWidth + 1 - w);
		t = it.t;
		val = it.rs - it.rt;
		case (it.ctrl.op)
			opAdd: val = it.rs + it.rt;
			opSub: ;
			opAdc:
			begin
				wide = a + b + it.t;
				val = wide[DataWidth-1:0];
				t = wide[w];
			end
			opSbb:
			begin
				wide = a + {1'b0, ~it.rt & mask} + !it.t;
				val = wide[DataWidth-1:0];
				t = !wide[w];
			end
			opTst:
			begin
				val = it.rs & it.rt;
				t = ((val & mask) == '0);
			end
			opAnd:   val = it.rs & it.rt;
			opOr:    val = it.rs | it.rt;
			opXor:   val = it.rs ^ it.rt;
			opCselT: val = it.t ? it.rs : it.rt;
			opCmpNe: t = (a != b);
			opCmpEq: t = (a == b);
			opCmpHs: t = (a >= b);
			opCmpHi: t = (a > b);
			opCmpGe: t = (sa >= sb);
			opCmpGt: t = (sa > sb);
			default: val = '0;
		endcase
		if (!it.ctrl.qword)
			val = {{(DataWidth-HalfWidth){val[HalfWidth-1] & !it.ctrl.zext}},
				val[HalfWidth-1:0]};
		return {t, val};
	endfunction

	// history moves only on unheld edges as the pipeline does
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			held   <= '0;
			expVal <= '0;
			expT   <= 1'b0;
		end
		else if (!exHold)
		begin
			held <= {ctrl, valRs, valRt, srT};
			{expT, expVal} <= expectResult(held);
		end
	end

	valueCheck: assert property (@(posedge clock) disable iff (!rstN) valOut == expVal)
		else
		begin
			aluTb.failCount++;
			$error("error at %0t: valOut got %h expected %h",
				$time, $sampled(valOut), $sampled(expVal));
		end

	tCheck: assert property (@(posedge clock) disable iff (!rstN) srTOut == expT)
		else
		begin
			aluTb.failCount++;
			$error("error at %0t: srTOut got %b expected %b",
				$time, $sampled(srTOut), $sampled(expT));
		end

	holdCheck: assert property (@(posedge clock) disable iff (!rstN)
		exHold |=> $stable(valOut) && $stable(srTOut))
		else
		begin
			aluTb.failCount++;
			$error("outputs changed at %0t while exHold was high", $time);
		end

	resetCheck: assert property (@(posedge clock) $rose(rstN) |-> valOut == '0 && !srTOut)
		else
		begin
			aluTb.failCount++;
			$error("outputs not cleared by reset at %0t", $time);
		end

endmodule

`default_nettype wire

// File: aluOperandStage.sv
/*
 * First ALU stage.
 * Forms the add and subtract results, the logic and CSELT value,
 * the compare flags of Rs - Rt and the TST zero bits, and registers
 * them together with ctrl and T. Holds while exHold is high.
 */
`default_nettype none

module aluOperandStage #(
	parameter int DataWidth = aluPkg::DataWidth
) (
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    exHold,
	input  wire aluPkg::aluCtrl_t  ctrl,
	input  wire  [DataWidth-1:0]   valRs,
	input  wire  [DataWidth-1:0]   valRt,
	input  wire                    srT,
	output aluPkg::stageReg_t      stageOut
);

	import aluPkg::*;

	logic [DataWidth-1:0] addSum;
	logic [DataWidth-1:0] subSum;
	logic [DataWidth-1:0] andVal;
	logic [DataWidth-1:0] logicVal;
	logic                 addCarry32;
	logic                 addCarry64;
	logic                 subCarry32;
	logic                 subCarry64;
	logic                 addCarryIn;
	logic                 subCarryIn;
	logic                 useAdd;
	condFlags_t           flags;
	stageReg_t            nextStage;

	// ADC feeds T in, SBB feeds the inverted borrow in
	assign addCarryIn = (ctrl.op == opAdc) && srT;
	assign subCarryIn = (ctrl.op == opSbb) ? !srT : 1'b1;

	carrySelectAdder #(
		.Width    (DataWidth),
		.SegWidth (SegWidth)
	) addUnit (
		.a         (valRs),
		.b         (valRt),
		.invertB   (1'b0),
		.carryIn   (addCarryIn),
		.sum       (addSum),
		.carryHalf (addCarry32),
		.carryFull (addCarry64)
	);

	carrySelectAdder #(
		.Width    (DataWidth),
		.SegWidth (SegWidth)
	) subUnit (
		.a         (valRs),
		.b         (valRt),
		.invertB   (1'b1),
		.carryIn   (subCarryIn),
		.sum       (subSum),
		.carryHalf (subCarry32),
		.carryFull (subCarry64)
	);

	assign useAdd = (ctrl.op == opAdd) || (ctrl.op == opAdc);
	assign andVal = valRs & valRt;

	always_comb
	begin
		case (ctrl.op)
			opTst, opAnd: logicVal = andVal;
			opOr:         logicVal = valRs | valRt;
			opXor:        logicVal = valRs ^ valRt;
			opCselT:      logicVal = srT ? valRs : valRt;
			default:      logicVal = '0;
		endcase
	end

	// carry set means no borrow, i.e. Rs >= Rt unsigned
	assign flags.zero32  = (subSum[HalfWidth-1:0] == '0);
	assign flags.carry32 = subCarry32;
	assign flags.sign32  = subSum[HalfWidth-1];
	assign flags.ovf32   = (valRs[HalfWidth-1] ^ valRt[HalfWidth-1]) &&
		(subSum[HalfWidth-1] ^ valRs[HalfWidth-1]);
	assign flags.zero64  = (subSum == '0);
	assign flags.carry64 = subCarry64;
	assign flags.sign64  = subSum[DataWidth-1];
	assign flags.ovf64   = (valRs[DataWidth-1] ^ valRt[DataWidth-1]) &&
		(subSum[DataWidth-1] ^ valRs[DataWidth-1]);

	always_comb
	begin
		nextStage.ctrl       = ctrl;
		nextStage.srT        = srT;
		nextStage.sum        = useAdd ? addSum : subSum;
		nextStage.sumCarry32 = useAdd ? addCarry32 : subCarry32;
		nextStage.sumCarry64 = useAdd ? addCarry64 : subCarry64;
		nextStage.logicVal   = logicVal;
		nextStage.flags      = flags;
		nextStage.tstZero32  = (andVal[HalfWidth-1:0] == '0);
		nextStage.tstZero64  = (andVal == '0);
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			stageOut <= '0;
		else if (!exHold)
			stageOut <= nextStage;
	end

endmodule

`default_nettype wire

// File: aluPkg.sv
/*
 * Shared definitions for the two-stage integer ALU.
 * Holds the default widths, the opcode encoding and the packed
 * structs that travel between the operand and result stages.
 */
`default_nettype none

package aluPkg;

	localparam int DataWidth = 64;
	localparam int SegWidth = 16;
	localparam int HalfWidth = 32;

	// opcode encoding follows the execute unit's 4-bit op field
	typedef enum logic [3:0] {
		opAdd      = 4'h0,
		opSub      = 4'h1,
		opAdc      = 4'h2,
		opSbb      = 4'h3,
		opTst      = 4'h4,
		opAnd      = 4'h5,
		opOr       = 4'h6,
		opXor      = 4'h7,
		opCmpNe    = 4'h8,
		opCmpHs    = 4'h9,
		opCmpGe    = 4'hA,
		opReserved = 4'hB,
		opCmpEq    = 4'hC,
		opCmpHi    = 4'hD,
		opCmpGt    = 4'hE,
		opCselT    = 4'hF
	} aluOp_e;

	typedef struct packed {
		logic   qword;
		logic   zext;
		aluOp_e op;
	} aluCtrl_t;

	// flags of Rs - Rt, once for the low word and once for the full qword
	typedef struct packed {
		logic zero32;
		logic carry32;
		logic sign32;
		logic ovf32;
		logic zero64;
		logic carry64;
		logic sign64;
		logic ovf64;
	} condFlags_t;

	typedef struct packed {
		aluCtrl_t               ctrl;
		logic                   srT;
		logic [DataWidth-1:0]   sum;
		logic                   sumCarry32;
		logic                   sumCarry64;
		logic [DataWidth-1:0]   logicVal;
		condFlags_t             flags;
		logic                   tstZero32;
		logic                   tstZero64;
	} stageReg_t;

endpackage

`default_nettype wire

// File: aluResultStage.sv
/*
 * Second ALU stage.
 * Picks the result value and the new T bit per opcode from the
 * registered stage-1 data, sign- or zero-extends in 32-bit mode and
 * registers valOut and srTOut. Holds while exHold is high.
 */
`default_nettype none

module aluResultStage #(
	parameter int DataWidth = aluPkg::DataWidth
) (
	input  wire                     clock,
	input  wire                     rstN,
	input  wire                     exHold,
	input  wire aluPkg::stageReg_t  stageIn,
	output logic [DataWidth-1:0]    valOut,
	output logic                    srTOut
);

	import aluPkg::*;

	logic [DataWidth-1:0] resultVal;
	logic [DataWidth-1:0] extVal;
	logic                 resultT;
	logic                 qword;
	logic                 extBit;
	logic                 zeroW;
	logic                 carryW;
	logic                 signedLt;
	logic                 tstZeroW;
	logic                 sumCarryW;

	assign qword = stageIn.ctrl.qword;

	// flag set for the active width
	assign zeroW     = qword ? stageIn.flags.zero64  : stageIn.flags.zero32;
	assign carryW    = qword ? stageIn.flags.carry64 : stageIn.flags.carry32;
	assign signedLt  = qword ?
		(stageIn.flags.sign64 ^ stageIn.flags.ovf64) :
		(stageIn.flags.sign32 ^ stageIn.flags.ovf32);
	assign tstZeroW  = qword ? stageIn.tstZero64 : stageIn.tstZero32;
	assign sumCarryW = qword ? stageIn.sumCarry64 : stageIn.sumCarry32;

	always_comb
	begin
		resultVal = stageIn.sum;
		resultT   = stageIn.srT;
		case (stageIn.ctrl.op)
			opAdd, opSub: ;
			opAdc:   resultT = sumCarryW;
			opSbb:   resultT = !sumCarryW;
			opTst:
			begin
				resultVal = stageIn.logicVal;
				resultT   = tstZeroW;
			end
			opAnd, opOr, opXor, opCselT: resultVal = stageIn.logicVal;
			opCmpNe: resultT = !zeroW;
			opCmpEq: resultT = zeroW;
			opCmpHs: resultT = carryW;
			opCmpHi: resultT = carryW && !zeroW;
			opCmpGe: resultT = !signedLt;
			opCmpGt: resultT = !signedLt && !zeroW;
			// opReserved
			default: resultVal = '0;
		endcase
	end

	// 32-bit mode keeps the low word and fills above it
	assign extBit = !stageIn.ctrl.zext && resultVal[HalfWidth-1];
	assign extVal = qword ? resultVal :
		{{(DataWidth-HalfWidth){extBit}}, resultVal[HalfWidth-1:0]};

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			valOut <= '0;
			srTOut <= 1'b0;
		end
		else if (!exHold)
		begin
			valOut <= extVal;
			srTOut <= resultT;
		end
	end

endmodule

`default_nettype wire

// File: aluTb.sv
/*
 * Testbench for the two-stage ALU.
 * Runs reset, directed corner operands, LCG-random streams and
 * streams broken by exHold stretches. The bound aluChecker does the
 * checking and counts its failures here.
 */
`default_nettype none

module aluTb;
	timeunit 1ns;
	timeprecision 100ps;

	import aluPkg::*;

	localparam int ClockPeriod = 4;
	localparam int NumRand = 6;
	localparam int StreamLen = 48;
	localparam int HoldMax = 3;
	localparam int DrainCycles = 4;
	// issue cycles of all tests with every hold at its longest
	localparam int PlannedCycles = 2 + 4 * 3 * (NumRand + 10) + 5 * 3 * (NumRand + 2) +
		7 * 3 * (NumRand + 6) + StreamLen + StreamLen * (1 + HoldMax) + 6 * DrainCycles;

	logic                 clock;
	logic                 rstN;
	logic                 exHold;
	aluCtrl_t             ctrl;
	logic [DataWidth-1:0] valRs;
	logic [DataWidth-1:0] valRt;
	logic                 srT;
	logic [DataWidth-1:0] valOut;
	logic                 srTOut;
	logic [63:0]          lcgState = 64'd71844;
	int                   failCount = 0;
	int                   itemCount = 0;
	int                   testCount = 0;

	aluTop #(
		.DataWidth (DataWidth)
	) i_dut (
		.clock  (clock),
		.rstN   (rstN),
		.exHold (exHold),
		.ctrl   (ctrl),
		.valRs  (valRs),
		.valRt  (valRt),
		.srT    (srT),
		.valOut (valOut),
		.srTOut (srTOut)
	);

	bind aluTop aluChecker #(
		.DataWidth (DataWidth)
	) assertUnit (
		.clock  (clock),
		.rstN   (rstN),
		.exHold (exHold),
		.ctrl   (ctrl),
		.valRs  (valRs),
		.valRt  (valRt),
		.srT    (srT),
		.valOut (valOut),
		.srTOut (srTOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	function logic [31:0] nextRand();
		lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcgState[63:32];
	endfunction

	function logic randBit();
		logic [31:0] r;
		r = nextRand();
		return r[31];
	endfunction

	function logic [DataWidth-1:0] rand64();
		return {nextRand(), nextRand()};
	endfunction

	// carries across segment and half-word boundaries
	function automatic logic [2*DataWidth-1:0] arithCorner(int i);
		case (i)
			0: return {64'hFFFF_FFFF_FFFF_FFFF, 64'h1};
			1: return {64'h0000_0000_0000_FFFF, 64'h1};
			2: return {64'h0000_0000_FFFF_FFFF, 64'h1};
			3: return {64'h0000_FFFF_FFFF_FFFF, 64'h1};
			default: return {64'h7FFF_FFFF_FFFF_FFFF, 64'h1};
		endcase
	endfunction

	// equal pairs and most-negative against positive for both widths
	function automatic logic [2*DataWidth-1:0] compareCorner(int i, logic [DataWidth-1:0] x);
		case (i)
			0: return {x, x};
			1: return {64'h8000_0000_0000_0000, 64'h1};
			2: return {64'h1, 64'h8000_0000_0000_0000};
			3: return {64'h0000_0000_8000_0000, 64'h1};
			4: return {64'h1, 64'h0000_0000_8000_0000};
			default: return {x, ~x[DataWidth-1:HalfWidth], x[HalfWidth-1:0]};
		endcase
	endfunction

	task automatic issue(aluOp_e op, logic qword, logic zext,
		logic [DataWidth-1:0] rs, logic [DataWidth-1:0] rt, logic t);
		@(posedge clock);
		#1;
		exHold     = 1'b0;
		ctrl.op    = op;
		ctrl.qword = qword;
		ctrl.zext  = zext;
		valRs      = rs;
		valRt      = rt;
		srT        = t;
		itemCount++;
	endtask

	task automatic holdFor(int cycles);
		logic [31:0] r;
		repeat (cycles)
		begin
			@(posedge clock);
			#1;
			r = nextRand();
			exHold = 1'b1;
			// inputs wander under hold and must be ignored
			ctrl = aluCtrl_t'(r[5:0]);
			valRs = rand64();
			valRt = rand64();
			srT = r[31];
		end
	endtask

	task automatic finishTest(string name, int failsBefore, int itemsBefore);
		repeat (DrainCycles) @(posedge clock);
		#1;
		testCount++;
		$display("test %s: %0d items, %0d failures", name,
			itemCount - itemsBefore, failCount - failsBefore);
	endtask

	task automatic applyReset();
		repeat (2) @(posedge clock);
		#1;
		rstN = 1'b1;
		finishTest("reset", 0, 0);
	endtask

	task automatic arithSweep();
		aluOp_e                 ops [4] = '{opAdd, opSub, opAdc, opSbb};
		logic [2*DataWidth-1:0] pair;
		int                     fails;
		int                     items;
		fails = failCount;
		items = itemCount;
		foreach (ops[o])
			for (int m = 0; m < 3; m++)
			begin
				for (int n = 0; n < NumRand; n++)
					issue(ops[o], m == 0, m == 2, rand64(), rand64(), randBit());
				for (int c = 0; c < 5; c++)
				begin
					pair = arithCorner(c);
					issue(ops[o], m == 0, m == 2, pair[2*DataWidth-1:DataWidth],
						pair[DataWidth-1:0], 1'b0);
					issue(ops[o], m == 0, m == 2, pair[2*DataWidth-1:DataWidth],
						pair[DataWidth-1:0], 1'b1);
				end
			end
		finishTest("arithmetic", fails, items);
	endtask

	task automatic logicSweep();
		aluOp_e               ops [5] = '{opAnd, opOr, opXor, opTst, opCselT};
		logic [DataWidth-1:0] x;
		int                   fails;
		int                   items;
		fails = failCount;
		items = itemCount;
		foreach (ops[o])
			for (int m = 0; m < 3; m++)
			begin
				for (int n = 0; n < NumRand; n++)
					issue(ops[o], m == 0, m == 2, rand64(), rand64(), randBit());
				// disjoint operands make TST see zero
				x = rand64();
				issue(ops[o], m == 0, m == 2, x, ~x, 1'b0);
				issue(ops[o], m == 0, m == 2, x, ~x, 1'b1);
			end
		finishTest("logic", fails, items);
	endtask

	task automatic compareSweep();
		aluOp_e                 ops [7] = '{opCmpNe, opCmpHs, opCmpGe, opCmpEq,
			opCmpHi, opCmpGt, opReserved};
		logic [2*DataWidth-1:0] pair;
		int                     fails;
		int                     items;
		fails = failCount;
		items = itemCount;
		foreach (ops[o])
			for (int m = 0; m < 3; m++)
			begin
				for (int n = 0; n < NumRand; n++)
					issue(ops[o], m == 0, m == 2, rand64(), rand64(), randBit());
				for (int c = 0; c < 6; c++)
				begin
					pair = compareCorner(c, rand64());
					issue(ops[o], m == 0, m == 2, pair[2*DataWidth-1:DataWidth],
						pair[DataWidth-1:0], randBit());
				end
			end
		finishTest("compare", fails, items);
	endtask

	task automatic opStream(string name, logic withHold);
		logic [31:0] r;
		int          fails;
		int          items;
		fails = failCount;
		items = itemCount;
		for (int n = 0; n < StreamLen; n++)
		begin
			r = nextRand();
			if (withHold && r[31:30] == 2'b00)
				holdFor(1 + r[15:8] % HoldMax);
			issue(aluOp_e'(r[7:4]), r[0], r[1], rand64(), rand64(), r[2]);
		end
		finishTest(name, fails, items);
	endtask

	initial
	begin
		#(PlannedCycles * ClockPeriod + 100 * ClockPeriod);
		$display("timeout: run did not finish within %0d planned cycles", PlannedCycles);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		exHold = 1'b0;
		ctrl = '0;
		valRs = '0;
		valRt = '0;
		srT = 1'b0;
		applyReset();
		arithSweep();
		logicSweep();
		compareSweep();
		opStream("back-to-back", 1'b0);
		opStream("hold", 1'b1);
		$display("summary: %0d tests, %0d items, %0d failures",
			testCount, itemCount, failCount);
		if (failCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: aluTop.sv
/*
 * Two-stage integer ALU for the execute unit.
 * A result appears at valOut and srTOut two unheld clock edges after
 * its operands are sampled. exHold freezes both stages.
 */
`default_nettype none

module aluTop #(
	parameter int DataWidth = aluPkg::DataWidth
) (
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    exHold,
	input  wire aluPkg::aluCtrl_t  ctrl,
	input  wire  [DataWidth-1:0]   valRs,
	input  wire  [DataWidth-1:0]   valRt,
	input  wire                    srT,
	output logic [DataWidth-1:0]   valOut,
	output logic                   srTOut
);

	import aluPkg::*;

	stageReg_t stageOut;

	aluOperandStage #(
		.DataWidth (DataWidth)
	) operandStage (
		.clock    (clock),
		.rstN     (rstN),
		.exHold   (exHold),
		.ctrl     (ctrl),
		.valRs    (valRs),
		.valRt    (valRt),
		.srT      (srT),
		.stageOut (stageOut)
	);

	aluResultStage #(
		.DataWidth (DataWidth)
	) resultStage (
		.clock   (clock),
		.rstN    (rstN),
		.exHold  (exHold),
		.stageIn (stageOut),
		.valOut  (valOut),
		.srTOut  (srTOut)
	);

endmodule

`default_nettype wire

// File: carrySelectAdder.sv
/*
 * Segmented carry-select adder.
 * Each segment adds with carry-in 0 and 1 in parallel, and the
 * segment carries then pick one of the two. Optionally inverts b,
 * which with carryIn set gives a - b. Carry at the half point is
 * exported for 32-bit mode.
 */
`default_nettype none

module carrySelectAdder #(
	parameter int Width = 64,
	parameter int SegWidth = 16
) (
	input  wire  [Width-1:0] a,
	input  wire  [Width-1:0] b,
	input  wire              invertB,
	input  wire              carryIn,
	output logic [Width-1:0] sum,
	output logic             carryHalf,
	output logic             carryFull
);

	localparam int NumSeg = Width / SegWidth;

	logic [Width-1:0]  bEff;
	logic [SegWidth:0] segSum0 [NumSeg];
	logic [SegWidth:0] segSum1 [NumSeg];
	// segCarry[i] is the carry into segment i
	logic [NumSeg:0]   segCarry;

	assign bEff = invertB ? ~b : b;
	assign segCarry[0] = carryIn;

	for (genvar i = 0; i < NumSeg; i++)
	begin : g_seg
		// both candidate sums are ready before the carry arrives
		assign segSum0[i] = {1'b0, a[i*SegWidth +: SegWidth]} +
			{1'b0, bEff[i*SegWidth +: SegWidth]};
		assign segSum1[i] = {1'b0, a[i*SegWidth +: SegWidth]} +
			{1'b0, bEff[i*SegWidth +: SegWidth]} + 1'b1;

		assign segCarry[i+1] = segCarry[i] ? segSum1[i][SegWidth] : segSum0[i][SegWidth];
		assign sum[i*SegWidth +: SegWidth] = segCarry[i] ?
			segSum1[i][SegWidth-1:0] : segSum0[i][SegWidth-1:0];
	end

	assign carryHalf = segCarry[NumSeg/2];
	assign carryFull = segCarry[NumSeg];

endmodule

`default_nettype wire
